/* logic/cache_geom_pkg.sv */
package cache_geom_pkg;

  // ----------------------------------------
  // address split: | page tag | tlb idx | cache idx | byte |
  // ----------------------------------------
  localparam int cache_idx_lsb = 2;   // word index within the cache
  localparam int tlb_idx_lsb   = 10;  // tlb slot, also low part of line tag
  localparam int page_tag_lsb  = 18;  // virtual or physical page

  typedef logic [7:0]  cache_idx_t;   // addr[9:2]
  typedef logic [7:0]  tlb_idx_t;     // addr[17:10]
  typedef logic [13:0] page_tag_t;    // addr[31:18]

  // stored per cache word, physical page followed by tlb index
  typedef logic [$bits(page_tag_t)+$bits(tlb_idx_t)-1:0] line_tag_t;

endpackage

/* logic/mem_bus_pkg.sv */
package mem_bus_pkg;

  typedef logic [31:0] mem_word_t;  // one bus word

  // ----------------------------------------
  // tlb write word layout
  // ----------------------------------------
  localparam int tlb_tag_bits = 14;
  localparam int tlb_ptag_lsb = 16;  // physical tag in bits 29..16
  localparam int tlb_vtag_lsb = 0;   // virtual tag in bits 13..0

  // entry as held in the tlb ram
  typedef struct packed {
    logic [tlb_tag_bits-1:0] ptag;  // replaces the page tag on translation
    logic [tlb_tag_bits-1:0] vtag;  // must match the request page tag
  } tlb_entry_t;

endpackage

/* logic/dual_clock_ram.sv */
`timescale 1ns/1ps

module dual_clock_ram #(
  parameter int  addr_bits = 8,
  parameter type data_t    = logic [31:0]
) (
  input  logic                 CPU_CLK,
  input  logic                 rd_en,
  input  logic [addr_bits-1:0] rd_addr,
  output data_t                rd_data,
  input  logic                 MCU_CLK,
  input  logic                 wr_en,
  input  logic [addr_bits-1:0] wr_addr,
  input  data_t                wr_data
);

  data_t mem [0:(1<<addr_bits)-1];

  // registered read, cpu side
  always_ff @(posedge CPU_CLK)
  begin
    if (rd_en)
      rd_data <= mem[rd_addr];
  end

  // write port, memory side
  always_ff @(posedge MCU_CLK)
  begin
    if (wr_en)
      mem[wr_addr] <= wr_data;
  end

endmodule

/* logic/toggle_pulse_sync.sv */
`timescale 1ns/1ps

module toggle_pulse_sync #(
  parameter int sync_stages = 2
) (
  input  logic dst_clk,
  input  logic RST,
  input  logic toggle_in,
  output logic pulse
);

  // sync_stages synchronizer flops plus one edge-detect flop
  logic [sync_stages:0] sync_q;

  always_ff @(posedge dst_clk)
  begin
    if (!RST)
      sync_q <= '0;
    else
      sync_q <= {sync_q[sync_stages-1:0], toggle_in};
  end

  assign pulse = sync_q[sync_stages] ^ sync_q[sync_stages-1];  // one flip, one pulse

  // the source must not toggle faster than the destination can see
  a_pulse_single: assert property (@(posedge dst_clk) disable iff (!RST)
    pulse |=> !pulse)
    else $error("toggle_pulse_sync: pulse held two cycles");

endmodule

/* logic/cache_lookup.sv */
`timescale 1ns/1ps

module cache_lookup (
  input  logic                       CPU_CLK,
  input  logic                       RST,
  input  logic [31:0]                cpu_addr,
  input  mem_bus_pkg::mem_word_t     cpu_wdata,
  input  logic                       cpu_we,
  input  logic                       cpu_enable,
  input  logic                       cpu_tlb_we,
  input  logic                       cache_inhibit,
  input  logic                       vmem_act,
  input  logic                       rsp_pulse,
  input  mem_bus_pkg::mem_word_t     rsp_data,
  output mem_bus_pkg::mem_word_t     cpu_rdata,
  output logic                       cache_busy,
  output logic                       mmu_fault,
  output logic                       ram_rd_en,
  output cache_geom_pkg::cache_idx_t ram_rd_idx,
  output cache_geom_pkg::tlb_idx_t   tlb_rd_idx,
  output logic                       job_toggle,
  output logic [31:0]                job_addr,
  output mem_bus_pkg::mem_word_t     job_data,
  output logic                       job_we,
  output logic                       job_tlb,
  input  mem_bus_pkg::mem_word_t     data_q,
  input  cache_geom_pkg::line_tag_t  tag_q,
  input  mem_bus_pkg::tlb_entry_t    tlb_q
);
  import cache_geom_pkg::*;
  import mem_bus_pkg::*;

  logic        s1_vld, s1_we, s1_tlb, s1_vmem;
  logic [31:0] s1_addr;
  mem_word_t   s1_data;
  logic        s2_vld, s2_we, s2_tlb, s2_vmem, s2_line_vld;
  logic [31:0] s2_addr;
  mem_word_t   s2_data;
  logic        pend_vld, pend_we, pend_tlb, pend_vmem;
  logic [31:0] pend_addr;
  mem_word_t   pend_data;
  logic [(1<<$bits(cache_idx_t))-1:0] line_vld;

  logic       offer, pipe_busy, take_pend, take_new;
  logic       fault, hit, launch;
  page_tag_t  virt_tag, phys_tag;
  tlb_idx_t   s2_tlb_idx;
  cache_idx_t job_idx;

  // ----------------------------------------
  // request intake
  // ----------------------------------------
  assign offer     = (cpu_enable || cpu_tlb_we) && !cache_inhibit;
  assign pipe_busy = s1_vld || s2_vld;                    // one lookup in flight at a time
  assign take_pend = pend_vld && !cache_busy && !pipe_busy;
  assign take_new  = offer && !cache_busy && !pipe_busy && !pend_vld;

  assign ram_rd_en  = s1_vld;
  assign ram_rd_idx = s1_addr[cache_idx_lsb +: $bits(cache_idx_t)];
  assign tlb_rd_idx = s1_addr[tlb_idx_lsb +: $bits(tlb_idx_t)];

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      s1_vld   <= 1'b0;
      s2_vld   <= 1'b0;
      pend_vld <= 1'b0;
    end
    else
    begin
      s1_vld <= take_pend || take_new;
      s2_vld <= s1_vld;
      if (take_pend)
        pend_vld <= offer;                                // slot refills if offered now
      else if (offer && !take_new)
        pend_vld <= 1'b1;
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (take_pend)
    begin
      s1_addr <= pend_addr;
      s1_data <= pend_data;
      s1_we   <= pend_we;
      s1_tlb  <= pend_tlb;
      s1_vmem <= pend_vmem;
    end
    else if (take_new)
    begin
      s1_addr <= cpu_addr;
      s1_data <= cpu_wdata;
      s1_we   <= cpu_we;
      s1_tlb  <= cpu_tlb_we;
      s1_vmem <= vmem_act;
    end
    if (offer && !take_new)                               // latest offer wins
    begin
      pend_addr <= cpu_addr;
      pend_data <= cpu_wdata;
      pend_we   <= cpu_we;
      pend_tlb  <= cpu_tlb_we;
      pend_vmem <= vmem_act;
    end
    s2_addr     <= s1_addr;
    s2_data     <= s1_data;
    s2_we       <= s1_we;
    s2_tlb      <= s1_tlb;
    s2_vmem     <= s1_vmem;
    s2_line_vld <= line_vld[ram_rd_idx];                  // sampled alongside the ram read
  end

  // ----------------------------------------
  // compare and decide
  // ----------------------------------------
  assign virt_tag   = s2_addr[page_tag_lsb +: $bits(page_tag_t)];
  assign s2_tlb_idx = s2_addr[tlb_idx_lsb +: $bits(tlb_idx_t)];
  assign phys_tag   = s2_vmem ? tlb_q.ptag : virt_tag;
  assign fault      = s2_vld && !s2_tlb && s2_vmem && (tlb_q.vtag != virt_tag);
  assign hit        = s2_line_vld && (tag_q == {phys_tag, s2_tlb_idx});
  assign launch     = s2_vld && !fault && (s2_tlb || s2_we || !hit);
  assign job_idx    = job_addr[cache_idx_lsb +: $bits(cache_idx_t)];

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      cache_busy <= 1'b0;
      mmu_fault  <= 1'b0;
      job_toggle <= 1'b0;
      line_vld   <= '0;
    end
    else
    begin
      mmu_fault <= fault;
      if (launch)
      begin
        cache_busy <= 1'b1;
        job_toggle <= !job_toggle;
      end
      else if (rsp_pulse)
        cache_busy <= 1'b0;
      if (rsp_pulse)
        line_vld[job_idx] <= !job_tlb;                    // tlb writes also hit memory, drop the line
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (launch)
    begin
      job_addr <= s2_tlb ? s2_addr : {phys_tag, s2_addr[page_tag_lsb-1:0]};
      job_data <= s2_data;
      job_we   <= s2_we;
      job_tlb  <= s2_tlb;
    end
    if (s2_vld && !fault && !s2_tlb && !s2_we && hit)
      cpu_rdata <= data_q;
    else if (rsp_pulse && !job_we && !job_tlb)
      cpu_rdata <= rsp_data;                              // miss data from the memory side
  end

  a_job_when_idle: assert property (@(posedge CPU_CLK) disable iff (!RST)
    $changed(job_toggle) |-> cache_busy && !$past(cache_busy))
    else $error("cache_lookup: job issued while busy");

  a_fault_no_job: assert property (@(posedge CPU_CLK) disable iff (!RST)
    mmu_fault |-> !$changed(job_toggle) && !cache_busy)
    else $error("cache_lookup: fault together with a job");

endmodule

/* logic/mem_fill_engine.sv */
`timescale 1ns/1ps

module mem_fill_engine (
  input  logic                       MCU_CLK,
  input  logic                       RST,
  input  logic                       job_start,
  input  logic [31:0]                job_addr,
  input  mem_bus_pkg::mem_word_t     job_data,
  input  logic                       job_we,
  input  logic                       job_tlb,
  input  logic                       mem_ack,
  input  mem_bus_pkg::mem_word_t     mem_rdata,
  input  logic                       mem_grant,
  output logic [31:0]                mem_addr,
  output mem_bus_pkg::mem_word_t     mem_wdata,
  output logic                       mem_we,
  output logic                       mem_req,
  output logic                       rsp_toggle,
  output mem_bus_pkg::mem_word_t     rsp_data,
  output logic                       data_wr_en,
  output cache_geom_pkg::cache_idx_t data_wr_idx,
  output mem_bus_pkg::mem_word_t     data_wr_word,
  output cache_geom_pkg::line_tag_t  tag_wr_tag,
  output logic                       tlb_wr_en,
  output cache_geom_pkg::tlb_idx_t   tlb_wr_idx,
  output mem_bus_pkg::tlb_entry_t    tlb_wr_entry
);
  import cache_geom_pkg::*;
  import mem_bus_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_commit
  } state_t;

  state_t state;
  logic   we_q;            // write strobe level until the ack
  logic   op_we, op_tlb;
  logic   bus_done;

  // ----------------------------------------
  // bus side shared with dma through the grant
  // ----------------------------------------
  assign mem_req  = (state == st_request) && mem_grant;
  assign mem_we   = we_q && mem_grant;
  assign bus_done = mem_req && mem_ack;

  always_ff @(posedge MCU_CLK)
  begin
    if (!RST)
    begin
      state      <= st_idle;
      we_q       <= 1'b0;
      rsp_toggle <= 1'b0;
    end
    else
    begin
      case (state)
        st_idle:
          if (job_start)
          begin
            state <= st_request;
            we_q  <= job_we || job_tlb;  // tlb update goes out as a store
          end
        st_request:
          if (bus_done)
          begin
            state <= st_commit;
            we_q  <= 1'b0;
          end
        st_commit:
        begin
          state      <= st_idle;
          rsp_toggle <= !rsp_toggle;     // ram write lands on this edge too
        end
        default:
          state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge MCU_CLK)
  begin
    if (state == st_idle && job_start)
    begin
      mem_addr  <= job_addr;
      mem_wdata <= job_data;
      op_we     <= job_we;
      op_tlb    <= job_tlb;
    end
    if (bus_done)
      rsp_data <= mem_rdata;             // held until the next ack
  end

  // ----------------------------------------
  // cache and tlb ram writes
  // ----------------------------------------
  assign data_wr_en   = (state == st_commit) && !op_tlb;
  assign data_wr_idx  = mem_addr[cache_idx_lsb +: $bits(cache_idx_t)];
  assign data_wr_word = op_we ? mem_wdata : rsp_data;
  assign tag_wr_tag   = mem_addr[tlb_idx_lsb +: $bits(line_tag_t)];

  assign tlb_wr_en         = (state == st_commit) && op_tlb;
  assign tlb_wr_idx        = mem_addr[tlb_idx_lsb +: $bits(tlb_idx_t)];
  assign tlb_wr_entry.ptag = mem_wdata[tlb_ptag_lsb +: tlb_tag_bits];
  assign tlb_wr_entry.vtag = mem_wdata[tlb_vtag_lsb +: tlb_tag_bits];

  a_we_with_req: assert property (@(posedge MCU_CLK) disable iff (!RST)
    mem_we |-> mem_req && (op_we || op_tlb))
    else $error("mem_fill_engine: mem_we without a store request");

endmodule

/* logic/snowball_cache.sv */
`timescale 1ns/1ps

module snowball_cache #(
  parameter int sync_stages = 2
) (
  input  logic                   CPU_CLK,
  input  logic                   MCU_CLK,
  input  logic                   RST,
  input  logic [31:0]            cpu_addr,
  input  mem_bus_pkg::mem_word_t cpu_wdata,
  input  logic                   cpu_we,
  input  logic                   cpu_enable,
  input  logic                   cpu_tlb_we,
  input  logic                   cache_inhibit,
  input  logic                   vmem_act,
  output mem_bus_pkg::mem_word_t cpu_rdata,
  output logic                   cache_busy,
  output logic                   mmu_fault,
  output logic [31:0]            mem_addr,
  output mem_bus_pkg::mem_word_t mem_wdata,
  output logic                   mem_we,
  output logic                   mem_req,
  input  logic                   mem_ack,
  input  mem_bus_pkg::mem_word_t mem_rdata,
  input  logic                   mem_grant
);
  import cache_geom_pkg::*;
  import mem_bus_pkg::*;

  // cpu side to memory side
  logic        job_toggle, job_start;
  logic [31:0] job_addr;
  mem_word_t   job_data;
  logic        job_we, job_tlb;
  // memory side back to cpu side
  logic        rsp_toggle, rsp_pulse;
  mem_word_t   rsp_data;
  // ram ports
  logic        ram_rd_en, data_wr_en, tlb_wr_en;
  cache_idx_t  ram_rd_idx, data_wr_idx;
  tlb_idx_t    tlb_rd_idx, tlb_wr_idx;
  mem_word_t   data_q, data_wr_word;
  line_tag_t   tag_q, tag_wr_tag;
  tlb_entry_t  tlb_q, tlb_wr_entry;

  cache_lookup u_lookup (
    .CPU_CLK(CPU_CLK), .RST(RST),
    .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata), .cpu_we(cpu_we),
    .cpu_enable(cpu_enable), .cpu_tlb_we(cpu_tlb_we),
    .cache_inhibit(cache_inhibit), .vmem_act(vmem_act),
    .rsp_pulse(rsp_pulse), .rsp_data(rsp_data),
    .cpu_rdata(cpu_rdata), .cache_busy(cache_busy), .mmu_fault(mmu_fault),
    .ram_rd_en(ram_rd_en), .ram_rd_idx(ram_rd_idx), .tlb_rd_idx(tlb_rd_idx),
    .job_toggle(job_toggle), .job_addr(job_addr), .job_data(job_data),
    .job_we(job_we), .job_tlb(job_tlb),
    .data_q(data_q), .tag_q(tag_q), .tlb_q(tlb_q)
  );

  mem_fill_engine u_fill (
    .MCU_CLK(MCU_CLK), .RST(RST), .job_start(job_start),
    .job_addr(job_addr), .job_data(job_data), .job_we(job_we), .job_tlb(job_tlb),
    .mem_ack(mem_ack), .mem_rdata(mem_rdata), .mem_grant(mem_grant),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_we(mem_we), .mem_req(mem_req),
    .rsp_toggle(rsp_toggle), .rsp_data(rsp_data),
    .data_wr_en(data_wr_en), .data_wr_idx(data_wr_idx), .data_wr_word(data_wr_word),
    .tag_wr_tag(tag_wr_tag),
    .tlb_wr_en(tlb_wr_en), .tlb_wr_idx(tlb_wr_idx), .tlb_wr_entry(tlb_wr_entry)
  );

  // ----------------------------------------
  // rams, read on CPU_CLK, written on MCU_CLK
  // ----------------------------------------
  dual_clock_ram #(.addr_bits($bits(cache_idx_t)), .data_t(mem_word_t)) u_cache_data (
    .CPU_CLK(CPU_CLK), .rd_en(ram_rd_en), .rd_addr(ram_rd_idx), .rd_data(data_q),
    .MCU_CLK(MCU_CLK), .wr_en(data_wr_en), .wr_addr(data_wr_idx), .wr_data(data_wr_word)
  );

  dual_clock_ram #(.addr_bits($bits(cache_idx_t)), .data_t(line_tag_t)) u_cache_tag (
    .CPU_CLK(CPU_CLK), .rd_en(ram_rd_en), .rd_addr(ram_rd_idx), .rd_data(tag_q),
    .MCU_CLK(MCU_CLK), .wr_en(data_wr_en), .wr_addr(data_wr_idx), .wr_data(tag_wr_tag)
  );

  dual_clock_ram #(.addr_bits($bits(tlb_idx_t)), .data_t(tlb_entry_t)) u_tlb (
    .CPU_CLK(CPU_CLK), .rd_en(ram_rd_en), .rd_addr(tlb_rd_idx), .rd_data(tlb_q),
    .MCU_CLK(MCU_CLK), .wr_en(tlb_wr_en), .wr_addr(tlb_wr_idx), .wr_data(tlb_wr_entry)
  );

  // ----------------------------------------
  // toggle crossings
  // ----------------------------------------
  toggle_pulse_sync #(.sync_stages(sync_stages)) u_job_sync (
    .dst_clk(MCU_CLK), .RST(RST), .toggle_in(job_toggle), .pulse(job_start)
  );

  toggle_pulse_sync #(.sync_stages(sync_stages)) u_rsp_sync (
    .dst_clk(CPU_CLK), .RST(RST), .toggle_in(rsp_toggle), .pulse(rsp_pulse)
  );

endmodule

/* verification/mcu_mem_model.sv */
`timescale 1ns/1ps

module mcu_mem_model (
  input  logic        MCU_CLK,
  input  logic        RST,
  input  logic [31:0] mem_addr,
  input  logic [31:0] mem_wdata,
  input  logic        mem_we,
  input  logic        mem_req,
  output logic        mem_ack,
  output logic [31:0] mem_rdata,
  output int unsigned wr_count,
  output logic [31:0] last_wr_addr,
  output logic [31:0] last_wr_data
);

  logic [31:0] log_addr [0:127];  // written words only
  logic [31:0] log_data [0:127];
  int          log_len = 0;
  int unsigned wait_left;

  function automatic logic [31:0] read_word(input logic [31:0] addr);
    logic [31:0] word;
    word = addr ^ 32'h5a5a_0000;  // fill pattern for untouched words
    for (int i = 0; i < log_len; i++)
      if (log_addr[i] == addr)
        word = log_data[i];
    return word;
  endfunction

  task automatic store_word(input logic [31:0] addr, input logic [31:0] data);
    int slot;
    begin
      slot = log_len;
      for (int i = 0; i < log_len; i++)
        if (log_addr[i] == addr)
          slot = i;
      log_addr[slot] = addr;
      log_data[slot] = data;
      if (slot == log_len)
        log_len++;
    end
  endtask

  always @(posedge MCU_CLK)
  begin
    if (!RST)
    begin
      mem_ack   <= 1'b0;
      wait_left <= $urandom_range(6, 1);
      wr_count  <= 0;
    end
    else if (mem_req && mem_ack)  // transfer taken on this edge
    begin
      mem_ack <= 1'b0;
      if (mem_we)
      begin
        store_word(mem_addr, mem_wdata);
        wr_count     <= wr_count + 1;
        last_wr_addr <= mem_addr;
        last_wr_data <= mem_wdata;
      end
    end
    else if (mem_req)
    begin
      if (wait_left > 1)
        wait_left <= wait_left - 1;
      else
      begin
        mem_ack   <= 1'b1;
        mem_rdata <= read_word(mem_addr);
        wait_left <= $urandom_range(6, 1);
      end
    end
    else
      mem_ack <= 1'b0;  // grant gone, drop the ack
  end

endmodule

/* verification/snowball_cache_tb.sv */
`timescale 1ns/1ps

module snowball_cache_tb;

  localparam int op_read  = 0;
  localparam int op_write = 1;
  localparam int op_tlb   = 2;
  localparam int hm_hit   = 0;  // read must hit
  localparam int hm_any   = 1;
  localparam int hm_miss  = 2;  // read must miss

  logic        CPU_CLK, MCU_CLK, RST;
  logic [31:0] cpu_addr, cpu_wdata, cpu_rdata;
  logic        cpu_we, cpu_enable, cpu_tlb_we, cache_inhibit, vmem_act;
  logic        cache_busy, mmu_fault;
  logic [31:0] mem_addr, mem_wdata, mem_rdata;
  logic        mem_we, mem_req, mem_ack, mem_grant;
  int unsigned wr_count;
  logic [31:0] last_wr_addr, last_wr_data;

  // reference state
  logic [31:0] sh_addr [0:127];
  logic [31:0] sh_data [0:127];
  int          sh_len = 0;
  logic [13:0] tlb_ptag [0:255];
  logic [13:0] tlb_vtag [0:255];
  logic [13:0] page_set [0:2] = '{14'h0012, 14'h0abc, 14'h1f00};
  logic [7:0]  tlb_set  [0:1] = '{8'h03, 8'h7e};
  logic [7:0]  cidx_set [0:2] = '{8'h10, 8'h11, 8'hc4};

  // expectations for the compare processes
  bit          job_allowed = 1'b0;
  bit          req_seen;
  logic [31:0] exp_mem_addr, exp_mem_wdata, exp_rdata;
  logic        exp_mem_we;
  event        rd_valid;
  int          n_checks = 0;
  int          n_errors = 0;
  int          n_timeouts = 0;

  snowball_cache #(.sync_stages(2)) u_dut (
    .CPU_CLK(CPU_CLK), .MCU_CLK(MCU_CLK), .RST(RST),
    .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata), .cpu_we(cpu_we),
    .cpu_enable(cpu_enable), .cpu_tlb_we(cpu_tlb_we),
    .cache_inhibit(cache_inhibit), .vmem_act(vmem_act),
    .cpu_rdata(cpu_rdata), .cache_busy(cache_busy), .mmu_fault(mmu_fault),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_we(mem_we), .mem_req(mem_req),
    .mem_ack(mem_ack), .mem_rdata(mem_rdata), .mem_grant(mem_grant)
  );

  mcu_mem_model u_mem (
    .MCU_CLK(MCU_CLK), .RST(RST), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_we(mem_we), .mem_req(mem_req), .mem_ack(mem_ack), .mem_rdata(mem_rdata),
    .wr_count(wr_count), .last_wr_addr(last_wr_addr), .last_wr_data(last_wr_data)
  );

  initial
  begin
    CPU_CLK = 1'b0;
    forever #20 CPU_CLK = ~CPU_CLK;
  end

  initial
  begin
    MCU_CLK = 1'b0;
    #1.5;  // edges of the two clocks never coincide
    forever #13 MCU_CLK = ~MCU_CLK;
  end

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  function automatic logic [31:0] shadow_word(input logic [31:0] addr);
    logic [31:0] word;
    word = addr ^ 32'h5a5a_0000;
    for (int i = 0; i < sh_len; i++)
      if (sh_addr[i] == addr)
        word = sh_data[i];
    return word;
  endfunction

  function automatic logic [31:0] phys_addr(input logic [31:0] addr, input logic vmem);
    return vmem ? {tlb_ptag[addr[17:10]], addr[17:0]} : addr;
  endfunction

  function automatic logic [31:0] expected_read(input logic [31:0] addr, input logic vmem);
    return shadow_word(phys_addr(addr, vmem));
  endfunction

  task automatic store_shadow(input logic [31:0] addr, input logic [31:0] data);
    int slot;
    begin
      slot = sh_len;
      for (int i = 0; i < sh_len; i++)
        if (sh_addr[i] == addr)
          slot = i;
      sh_addr[slot] = addr;
      sh_data[slot] = data;
      if (slot == sh_len)
        sh_len++;
    end
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("FAILED %0t: %s is %h, expected %h", $time, what, got, want);
    n_errors++;
  endtask

  // ----------------------------------------
  // compare processes
  // ----------------------------------------
  always @(rd_valid)
  begin
    n_checks++;
    if (cpu_rdata !== exp_rdata)
      report_mismatch("cpu_rdata", cpu_rdata, exp_rdata);
  end

  always @(negedge MCU_CLK)
  begin
    if (RST && mem_req)
    begin
      n_checks++;
      if (!job_allowed)
      begin
        $display("FAILED %0t: memory request at %h with no job expected", $time, mem_addr);
        n_errors++;
      end
      else if (mem_addr !== exp_mem_addr)
        report_mismatch("mem_addr", mem_addr, exp_mem_addr);
      else if (mem_we !== exp_mem_we)
        report_mismatch("mem_we", mem_we, exp_mem_we);
      else if (mem_we && mem_wdata !== exp_mem_wdata)
        report_mismatch("mem_wdata", mem_wdata, exp_mem_wdata);
      if (mem_ack)
        req_seen = 1'b1;  // transfer completes on the next edge
    end
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  task automatic start_access(input int op, input logic [31:0] addr,
                              input logic [31:0] data, input logic vmem);
    @(posedge CPU_CLK);
    cpu_addr   <= addr;
    cpu_wdata  <= data;
    cpu_we     <= (op == op_write);
    cpu_enable <= (op != op_tlb);
    cpu_tlb_we <= (op == op_tlb);
    vmem_act   <= vmem;
    @(posedge CPU_CLK);  // accepted on this edge
    cpu_enable <= 1'b0;
    cpu_tlb_we <= 1'b0;
  endtask

  task automatic wait_not_busy(output bit ok);
    int cycles;
    begin
      cycles = 0;
      while (cache_busy && cycles < 400)
      begin
        @(negedge CPU_CLK);
        cycles++;
      end
      ok = !cache_busy;
      if (!ok)
      begin
        $display("timeout: cache_busy still high after %0d cycles at %0t", cycles, $time);
        n_timeouts++;
      end
    end
  endtask

  task automatic access(input int op, input logic [31:0] addr, input logic [31:0] data,
                        input logic vmem, input int hit_mode, input int grant_hold);
    logic [31:0] phys;
    bit          fault_exp, busy_exp, ok;
    begin
      phys      = (op == op_tlb) ? addr : phys_addr(addr, vmem);
      fault_exp = (op != op_tlb) && vmem && (tlb_vtag[addr[17:10]] != addr[31:18]);
      busy_exp  = !fault_exp && (op != op_read || hit_mode == hm_miss);
      job_allowed   = !fault_exp && (op != op_read || hit_mode != hm_hit);
      exp_mem_addr  = phys;
      exp_mem_we    = (op != op_read);
      exp_mem_wdata = data;
      req_seen      = 1'b0;
      start_access(op, addr, data, vmem);
      repeat (2) @(posedge CPU_CLK);
      @(negedge CPU_CLK);  // outputs of edge N+2
      n_checks++;
      if (mmu_fault !== fault_exp)
        report_mismatch("mmu_fault", mmu_fault, fault_exp);
      if (!(op == op_read && hit_mode == hm_any) && cache_busy !== busy_exp)
        report_mismatch("cache_busy", cache_busy, busy_exp);
      if (fault_exp)
      begin
        @(negedge CPU_CLK);
        if (mmu_fault !== 1'b0)
          report_mismatch("mmu_fault one cycle later", mmu_fault, 1'b0);
      end
      for (int i = 0; i < grant_hold; i++)
      begin
        @(negedge CPU_CLK);
        n_checks++;
        if (mem_req || !cache_busy)
        begin
          $display("job did not wait for mem_grant at %0t", $time);
          n_errors++;
        end
      end
      if (grant_hold > 0)
      begin
        @(posedge CPU_CLK);
        mem_grant <= 1'b1;
        @(negedge CPU_CLK);
      end
      wait_not_busy(ok);
      if (ok && busy_exp && !req_seen)
      begin
        $display("no memory transfer seen for the job at %h", phys);
        n_errors++;
      end
      if (!fault_exp && op == op_write)
        store_shadow(phys, data);
      if (op == op_tlb)
      begin
        store_shadow(addr, data);  // tlb update is also a memory store
        tlb_ptag[addr[17:10]] = data[29:16];
        tlb_vtag[addr[17:10]] = data[13:0];
      end
      if (ok && op == op_read && !fault_exp)
      begin
        exp_rdata = expected_read(addr, vmem);
        -> rd_valid;
      end
      job_allowed = 1'b0;
    end
  endtask

  initial
  begin
    logic [31:0] addr;
    int          pick;
    int unsigned writes_before;
    void'($urandom(32'h96ca_1424));
    RST           = 1'b0;
    cpu_addr      = '0;
    cpu_wdata     = '0;
    cpu_we        = 1'b0;
    cpu_enable    = 1'b0;
    cpu_tlb_we    = 1'b0;
    cache_inhibit = 1'b0;
    vmem_act      = 1'b0;
    mem_grant     = 1'b1;
    repeat (4) @(posedge CPU_CLK);
    RST <= 1'b1;
    @(negedge CPU_CLK);
    n_checks++;
    if (cache_busy !== 1'b0 || mmu_fault !== 1'b0 || mem_req !== 1'b0 || mem_we !== 1'b0)
    begin
      $display("outputs not idle after reset");
      n_errors++;
    end

    // miss, then hit on the same word
    access(op_read, 32'h0001_2340, 32'h0, 1'b0, hm_miss, 0);
    access(op_read, 32'h0001_2340, 32'h0, 1'b0, hm_hit, 0);

    // write-through, one bus write, then a hit
    writes_before = wr_count;
    access(op_write, 32'h0004_5680, 32'hcafe_0001, 1'b0, hm_miss, 0);
    n_checks++;
    if (wr_count != writes_before + 1)
      report_mismatch("memory write count", wr_count, writes_before + 1);
    if (last_wr_addr !== 32'h0004_5680 || last_wr_data !== 32'hcafe_0001)
      report_mismatch("last memory write data", last_wr_data, 32'hcafe_0001);
    access(op_read, 32'h0004_5680, 32'h0, 1'b0, hm_hit, 0);

    // translation, then a fault on the same slot
    access(op_tlb, {14'h0100, 8'h21, 8'h05, 2'b00}, {2'b00, 14'h2222, 2'b00, 14'h0100},
           1'b0, hm_miss, 0);
    access(op_read, {14'h0100, 8'h21, 8'h07, 2'b00}, 32'h0, 1'b1, hm_miss, 0);
    access(op_read, {14'h0333, 8'h21, 8'h07, 2'b00}, 32'h0, 1'b1, hm_miss, 0);
    repeat (20) @(posedge MCU_CLK);

    // inhibited offers are dropped
    @(posedge CPU_CLK);
    cache_inhibit <= 1'b1;
    cpu_enable    <= 1'b1;
    vmem_act      <= 1'b0;
    cpu_addr      <= 32'h0009_9900;
    repeat (8)
    begin
      @(negedge CPU_CLK);
      n_checks++;
      if (cache_busy || mmu_fault)
      begin
        $display("request accepted while cache_inhibit was high");
        n_errors++;
      end
    end
    @(posedge CPU_CLK);
    cpu_enable    <= 1'b0;
    cache_inhibit <= 1'b0;

    // grant withheld for a while
    @(posedge CPU_CLK);
    mem_grant <= 1'b0;
    access(op_read, 32'h0009_9900, 32'h0, 1'b0, hm_miss, 30);

    // ----------------------------------------
    // random mix over a small address set
    // ----------------------------------------
    for (int t = 0; t < 2; t++)
      access(op_tlb, {page_set[t], tlb_set[t], cidx_set[t], 2'b00},
             {2'b00, page_set[2-t], 2'b00, page_set[t]}, 1'b0, hm_miss, 0);
    for (int n = 0; n < 300; n++)
    begin
      pick = $urandom_range(9, 0);
      addr = {page_set[$urandom_range(2, 0)], tlb_set[$urandom_range(1, 0)],
              cidx_set[$urandom_range(2, 0)], 2'b00};
      if (pick < 5)
        access(op_read, addr, 32'h0, pick[0], hm_any, 0);
      else if (pick < 8)
        access(op_write, addr, $urandom, pick[0], hm_miss, 0);
      else
        access(op_tlb, addr, {2'b00, page_set[$urandom_range(2, 0)], 2'b00,
               page_set[$urandom_range(2, 0)]}, 1'b0, hm_miss, 0);
    end

    $display("checks %0d, errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
    if (n_errors == 0 && n_timeouts == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* snowball_cache.f */
logic/cache_geom_pkg.sv
logic/mem_bus_pkg.sv
logic/dual_clock_ram.sv
logic/toggle_pulse_sync.sv
logic/cache_lookup.sv
logic/mem_fill_engine.sv
logic/snowball_cache.sv
verification/mcu_mem_model.sv
verification/snowball_cache_tb.sv
